// File: Bender.yml
package:
  name: mod_exp

sources:
  - include_dirs:
      - design
    files:
      - design/mod_exp_pkg.sv
      - design/word_mac.sv
      - design/operand_bank.sv
      - design/mont_mul.sv
      - design/exp_ctrl.sv
      - design/mod_exp_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/mod_exp_checker.sv
      - tests/mod_exp_sva.sv
      - tests/mod_exp_tb.sv

// File: design/exp_ctrl.sv
// exponent sequencer with leading-one scan and square and multiply steps
// holds m_bar and c_bar and streams the result words
`include "mod_exp_defines.svh"

module exp_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               start_input,
    input  logic               start_compute,
    input  logic               get_result,
    input  logic               load_done,
    input  mod_exp_pkg::vec_t  e_vec,
    input  mod_exp_pkg::vec_t  r_vec,
    input  mod_exp_pkg::vec_t  m_vec,
    input  mod_exp_pkg::vec_t  t_vec,
    input  logic               mul_done,
    input  mod_exp_pkg::vec_t  mul_result,
    output logic               load_start,
    output logic               mul_start,
    output mod_exp_pkg::vec_t  mul_a,
    output mod_exp_pkg::vec_t  mul_b,
    output logic               busy,
    output logic               result_ready,
    output logic               res_valid,
    output mod_exp_pkg::word_t res_word
);
    import mod_exp_pkg::*;

    localparam int BW = $clog2(`EXP_BITS);
    localparam int OW = $clog2(`NUM_WORDS);
    localparam logic [OW-1:0] LAST_WORD = OW'(`NUM_WORDS - 1);

    exp_state_t    state;
    logic [BW-1:0] bit_idx;    // current exponent bit
    logic [OW-1:0] out_idx;
    logic          mul_wait;   // product in flight
    logic          mul_step;
    vec_t          m_bar;
    vec_t          c_bar;

    assign load_start = start_input && (state == ST_IDLE || state == ST_COMPLETE);
    assign mul_step = state inside {ST_TO_MONT, ST_SQUARE, ST_MULTIPLY, ST_FROM_MONT};
    assign mul_start = mul_step && !mul_wait;
    assign busy = mul_step || state == ST_FIND_LEAD;
    assign result_ready = (state == ST_COMPLETE);
    assign res_valid = (state == ST_OUTPUT);
    assign res_word = res_valid ? c_bar[out_idx * `WORD_WIDTH +: `WORD_WIDTH] : '0;

    always_comb begin
        mul_a = c_bar;
        mul_b = c_bar;   // squaring by default
        case (state)
            ST_TO_MONT: begin
                mul_a = m_vec;
                mul_b = t_vec;
            end
            ST_MULTIPLY: mul_b = m_bar;
            ST_FROM_MONT: mul_a = vec_t'(1);
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            bit_idx <= '0;
            out_idx <= '0;
            mul_wait <= 1'b0;
        end else begin
            if (mul_start) mul_wait <= 1'b1;
            else if (mul_done) mul_wait <= 1'b0;
            case (state)
                ST_IDLE: if (load_start) state <= ST_LOADING;
                ST_LOADING: if (load_done) state <= ST_WAIT_COMPUTE;
                ST_WAIT_COMPUTE: if (start_compute) state <= ST_TO_MONT;
                ST_TO_MONT: begin
                    if (mul_done) begin
                        bit_idx <= BW'(`EXP_BITS - 1);
                        state <= ST_FIND_LEAD;
                    end
                end
                ST_FIND_LEAD: begin
                    if (e_vec[bit_idx]) state <= ST_SQUARE;
                    else if (bit_idx == '0) state <= ST_FROM_MONT;   // e is zero
                    else bit_idx <= bit_idx - 1'b1;
                end
                ST_SQUARE: begin
                    if (mul_done) begin
                        if (e_vec[bit_idx]) state <= ST_MULTIPLY;
                        else if (bit_idx == '0) state <= ST_FROM_MONT;
                        else bit_idx <= bit_idx - 1'b1;   // next square starts again
                    end
                end
                ST_MULTIPLY: begin
                    if (mul_done) begin
                        if (bit_idx == '0) begin
                            state <= ST_FROM_MONT;
                        end else begin
                            bit_idx <= bit_idx - 1'b1;
                            state <= ST_SQUARE;
                        end
                    end
                end
                ST_FROM_MONT: if (mul_done) state <= ST_COMPLETE;
                ST_COMPLETE: begin
                    if (load_start) begin
                        state <= ST_LOADING;
                    end else if (get_result) begin
                        out_idx <= '0;
                        state <= ST_OUTPUT;
                    end
                end
                default: begin
                    out_idx <= out_idx + 1'b1;
                    if (out_idx == LAST_WORD) state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mul_done) begin
            c_bar <= mul_result;
            if (state == ST_TO_MONT) begin
                m_bar <= mul_result;
                c_bar <= r_vec;   // one in Montgomery form
            end
        end
    end

endmodule

// File: design/mod_exp_defines.svh
// word and operand sizing of the modular exponentiator
`ifndef MOD_EXP_DEFINES_SVH
`define MOD_EXP_DEFINES_SVH

// bits per word
`define WORD_WIDTH 16
// words per operand
`define NUM_WORDS 4
// full operand width
`define VEC_WIDTH (`WORD_WIDTH * `NUM_WORDS)
// exponent bits scanned
`define EXP_BITS `VEC_WIDTH

`endif

// File: design/mod_exp_pkg.sv
// shared types of the modular exponentiator
// words, operands, multiply-add result and sequencer states
`include "mod_exp_defines.svh"

package mod_exp_pkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`VEC_WIDTH-1:0] vec_t;   // word 0 in the low bits

    // one double word as the whole product-sum or as its two halves
    typedef union packed {
        logic [2*`WORD_WIDTH-1:0] full;
        struct packed {
            word_t carry;   // high word
            word_t sum;     // low word
        } part;
    } mac_result_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOADING,
        ST_WAIT_COMPUTE,
        ST_TO_MONT,      // m_bar from m and t
        ST_FIND_LEAD,    // leading one of e
        ST_SQUARE,
        ST_MULTIPLY,
        ST_FROM_MONT,    // product of 1 and c_bar
        ST_COMPLETE,
        ST_OUTPUT
    } exp_state_t;

endpackage

// File: design/mod_exp_top.sv
// modular exponentiator top level
// operand storage, exponent sequencer and Montgomery multiplier
module mod_exp_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               start_input,
    input  logic               start_compute,
    input  logic               get_result,
    input  mod_exp_pkg::word_t m_word,
    input  mod_exp_pkg::word_t e_word,
    input  mod_exp_pkg::word_t n_word,
    input  mod_exp_pkg::word_t r_word,
    input  mod_exp_pkg::word_t t_word,
    input  mod_exp_pkg::word_t nprime0,
    output logic               busy,
    output logic               result_ready,
    output logic               res_valid,
    output mod_exp_pkg::word_t res_word
);
    import mod_exp_pkg::*;

    vec_t  m_vec;
    vec_t  e_vec;
    vec_t  n_vec;
    vec_t  r_vec;
    vec_t  t_vec;
    word_t n_prime;
    logic  load_start;
    logic  load_done;
    logic  mul_start;
    logic  mul_done;
    vec_t  mul_a;
    vec_t  mul_b;
    vec_t  mul_result;

    operand_bank operand_bank_i (
        .clk        (clk),
        .reset      (reset),
        .load_start (load_start),
        .m_word     (m_word),
        .e_word     (e_word),
        .n_word     (n_word),
        .r_word     (r_word),
        .t_word     (t_word),
        .nprime0    (nprime0),
        .m_vec      (m_vec),
        .e_vec      (e_vec),
        .n_vec      (n_vec),
        .r_vec      (r_vec),
        .t_vec      (t_vec),
        .n_prime    (n_prime),
        .load_done  (load_done)
    );

    exp_ctrl exp_ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .start_input   (start_input),
        .start_compute (start_compute),
        .get_result    (get_result),
        .load_done     (load_done),
        .e_vec         (e_vec),
        .r_vec         (r_vec),
        .m_vec         (m_vec),
        .t_vec         (t_vec),
        .mul_done      (mul_done),
        .mul_result    (mul_result),
        .load_start    (load_start),
        .mul_start     (mul_start),
        .mul_a         (mul_a),
        .mul_b         (mul_b),
        .busy          (busy),
        .result_ready  (result_ready),
        .res_valid     (res_valid),
        .res_word      (res_word)
    );

    mont_mul mont_mul_i (
        .clk     (clk),
        .reset   (reset),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .n       (n_vec),
        .n_prime (n_prime),
        .done    (mul_done),
        .result  (mul_result)
    );

endmodule

// File: design/mont_mul.sv
// word-serial Montgomery product a * b / R mod n over one multiply-add unit
// ends with a conditional subtraction so the result stays below n
`include "mod_exp_defines.svh"

module mont_mul (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  mod_exp_pkg::vec_t  a,
    input  mod_exp_pkg::vec_t  b,
    input  mod_exp_pkg::vec_t  n,
    input  mod_exp_pkg::word_t n_prime,
    output logic               done,
    output mod_exp_pkg::vec_t  result
);
    import mod_exp_pkg::*;

    localparam int WW = `WORD_WIDTH;
    localparam int NW = `NUM_WORDS;
    localparam int CW = $clog2(NW + 1);
    localparam logic [CW-1:0] LAST = CW'(NW - 1);
    localparam logic [CW-1:0] TOP = CW'(NW);

    localparam logic [2:0] P_IDLE   = 3'd0;
    localparam logic [2:0] P_MUL    = 3'd1;   // v += a[i] * b
    localparam logic [2:0] P_FOLD   = 3'd2;   // top carry into v[NW], v[NW+1]
    localparam logic [2:0] P_FACTOR = 3'd3;   // q = v[0] * n_prime
    localparam logic [2:0] P_RED    = 3'd4;   // v = (v + q * n) >> WW
    localparam logic [2:0] P_TOP1   = 3'd5;
    localparam logic [2:0] P_TOP2   = 3'd6;
    localparam logic [2:0] P_SUB    = 3'd7;   // v - n over NW + 1 words

    logic [2:0]             phase;
    logic [CW-1:0]          i;
    logic [CW-1:0]          j;
    logic                   k;        // low issues a step, high captures it
    logic                   j_last;
    logic [(NW+1)*WW-1:0]   n_ext;    // n with a zero top word
    word_t                  v [NW+2];
    word_t                  carry;
    word_t                  q;
    vec_t                   diff;
    vec_t                   v_low;
    logic                   ge;       // v >= n
    word_t                  mac_x;
    word_t                  mac_y;
    word_t                  mac_z;
    word_t                  mac_cin;
    mac_result_t            mac_out;

    word_mac word_mac_i (
        .clk      (clk),
        .x        (mac_x),
        .y        (mac_y),
        .z        (mac_z),
        .carry_in (mac_cin),
        .result   (mac_out)
    );

    assign j_last = (j == LAST);
    assign n_ext = {word_t'(0), n};
    assign mac_cin = (phase == P_FACTOR) ? '0 : carry;

    always_comb begin
        mac_x = '0;
        mac_y = '0;
        mac_z = v[j];
        case (phase)
            P_MUL: begin
                mac_x = a[i * WW +: WW];
                mac_y = b[j * WW +: WW];
            end
            P_FOLD, P_TOP1: mac_z = v[NW];
            P_FACTOR: begin
                mac_x = v[0];
                mac_y = n_prime;
                mac_z = '0;
            end
            P_RED: begin
                mac_x = q;
                mac_y = n_ext[j * WW +: WW];
            end
            P_TOP2: mac_z = v[NW + 1];
            P_SUB: begin
                mac_x = ~n_ext[j * WW +: WW];   // ones complement plus a carry in of one
                mac_y = word_t'(1);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= P_IDLE;
            i <= '0;
            j <= '0;
            k <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            k <= (phase != P_IDLE) && !k;
            if (phase == P_IDLE) begin
                if (start) begin
                    for (int w = 0; w < NW + 2; w++) begin
                        v[w] <= '0;
                    end
                    carry <= '0;
                    i <= '0;
                    j <= '0;
                    phase <= P_MUL;
                end
            end else if (k) begin
                carry <= mac_out.part.carry;
                case (phase)
                    P_MUL: begin
                        v[j] <= mac_out.part.sum;
                        j <= j_last ? '0 : j + 1'b1;
                        if (j_last) phase <= P_FOLD;
                    end
                    P_FOLD: begin
                        v[NW] <= mac_out.part.sum;
                        v[NW + 1] <= mac_out.part.carry;
                        phase <= P_FACTOR;
                    end
                    P_FACTOR: begin
                        q <= mac_out.part.sum;
                        carry <= '0;
                        phase <= P_RED;
                    end
                    P_RED: begin
                        if (j != '0) v[j - 1'b1] <= mac_out.part.sum;   // word 0 drops out
                        j <= j_last ? '0 : j + 1'b1;
                        if (j_last) phase <= P_TOP1;
                    end
                    P_TOP1: begin
                        v[NW - 1] <= mac_out.part.sum;
                        phase <= P_TOP2;
                    end
                    P_TOP2: begin
                        v[NW] <= mac_out.part.sum;
                        i <= i + 1'b1;
                        carry <= '0;
                        phase <= P_MUL;
                        if (i == LAST) begin
                            carry <= word_t'(1);
                            phase <= P_SUB;
                        end
                    end
                    default: begin
                        if (j == TOP) begin
                            ge <= mac_out.part.carry[0];   // no borrow out of the top word
                            done <= 1'b1;
                            j <= '0;
                            phase <= P_IDLE;
                        end else begin
                            diff[j * WW +: WW] <= mac_out.part.sum;
                            j <= j + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    always_comb begin
        for (int w = 0; w < NW; w++) begin
            v_low[w * WW +: WW] = v[w];
        end
    end

    assign result = ge ? diff : v_low;

endmodule

// File: design/operand_bank.sv
// operand storage for m, e, n, r, t and the low-word inverse
`include "mod_exp_defines.svh"

module operand_bank (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_start,
    input  mod_exp_pkg::word_t m_word,
    input  mod_exp_pkg::word_t e_word,
    input  mod_exp_pkg::word_t n_word,
    input  mod_exp_pkg::word_t r_word,
    input  mod_exp_pkg::word_t t_word,
    input  mod_exp_pkg::word_t nprime0,
    output mod_exp_pkg::vec_t  m_vec,
    output mod_exp_pkg::vec_t  e_vec,
    output mod_exp_pkg::vec_t  n_vec,
    output mod_exp_pkg::vec_t  r_vec,
    output mod_exp_pkg::vec_t  t_vec,
    output mod_exp_pkg::word_t n_prime,
    output logic               load_done
);

    localparam int IW = $clog2(`NUM_WORDS);
    localparam logic [IW-1:0] LAST = IW'(`NUM_WORDS - 1);

    logic          loading;
    logic [IW-1:0] idx;      // word being written

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loading <= 1'b0;
            idx <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= loading && idx == LAST;
            if (load_start) begin
                loading <= 1'b1;
                idx <= '0;
            end else if (loading) begin
                idx <= idx + 1'b1;
                if (idx == LAST) loading <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_start) n_prime <= nprime0;   // sampled with the start pulse
        if (loading) begin
            m_vec[idx * `WORD_WIDTH +: `WORD_WIDTH] <= m_word;
            e_vec[idx * `WORD_WIDTH +: `WORD_WIDTH] <= e_word;
            n_vec[idx * `WORD_WIDTH +: `WORD_WIDTH] <= n_word;
            r_vec[idx * `WORD_WIDTH +: `WORD_WIDTH] <= r_word;
            t_vec[idx * `WORD_WIDTH +: `WORD_WIDTH] <= t_word;
        end
    end

endmodule

// File: design/word_mac.sv
// registered multiply-accumulate of one word pair
`include "mod_exp_defines.svh"

module word_mac (
    input  logic                     clk,
    input  mod_exp_pkg::word_t       x,
    input  mod_exp_pkg::word_t       y,
    input  mod_exp_pkg::word_t       z,
    input  mod_exp_pkg::word_t       carry_in,
    output mod_exp_pkg::mac_result_t result
);

    localparam int DW = 2 * `WORD_WIDTH;

    // all inputs at maximum still fit in DW bits
    always_ff @(posedge clk) begin
        result.full <= DW'(x) * DW'(y) + DW'(z) + DW'(carry_in);
    end

endmodule

// File: flist.f
+incdir+design
design/mod_exp_pkg.sv
design/word_mac.sv
design/operand_bank.sv
design/mont_mul.sv
design/exp_ctrl.sv
design/mod_exp_top.sv
tests/mod_exp_checker.sv
tests/mod_exp_sva.sv
tests/mod_exp_tb.sv

// File: tests/mod_exp_checker.sv
// result checker for the modular exponentiator
// collects streamed words, compares them and keeps the counts
`include "mod_exp_defines.svh"

module mod_exp_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               busy,
    input  logic               result_ready,
    input  logic               res_valid,
    input  mod_exp_pkg::word_t res_word,
    output int                 streams_seen,
    output int                 fail_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import mod_exp_pkg::*;

    localparam int WW = `WORD_WIDTH;
    localparam int NW = `NUM_WORDS;

    string exp_name;
    vec_t  exp_value;
    vec_t  got;
    logic  armed = 1'b0;        // a result was requested
    logic  prev_valid = 1'b0;
    logic  zero_fault = 1'b0;   // reported once
    int    words = 0;
    int    streams = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    protocol_errors = 0;

    assign streams_seen = streams;
    assign fail_count = tests_failed + protocol_errors;

    task automatic expect_stream(string name, vec_t value);
        exp_name = name;
        exp_value = value;
        got = '0;
        words = 0;
        armed = 1'b1;
    endtask

    task automatic check_quiet(string name);
        @(negedge clk);
        tests_run++;
        if (busy || result_ready || res_valid) begin
            tests_failed++;
            $display("%s: control outputs not idle (busy %b, result_ready %b, res_valid %b)",
                     name, busy, result_ready, res_valid);
        end else begin
            $display("PASS %s", name);
        end
    endtask

    task automatic note_failure(string name, string what);
        tests_run++;
        tests_failed++;
        armed = 1'b0;
        $display("%s: %s", name, what);
    endtask

    task automatic close_stream();
        armed = 1'b0;
        streams++;
        tests_run++;
        if (words != NW) begin
            tests_failed++;
            $display("%s: result stream lasted %0d cycles instead of %0d", exp_name, words, NW);
        end else if (got !== exp_value) begin
            tests_failed++;
            $display("MISMATCH %s: expected %h actual %h", exp_name, exp_value, got);
        end else begin
            $display("PASS %s", exp_name);
        end
    endtask

    task automatic report_totals();
        $display("%0d tests run, %0d passed, %0d failed, %0d protocol errors",
                 tests_run, tests_run - tests_failed, tests_failed, protocol_errors);
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (res_valid) begin
                if (!armed && !prev_valid) begin
                    protocol_errors++;
                    $display("res_valid rose although no result was requested");
                end
                if (armed && words < NW) got[words * WW +: WW] = res_word;
                if (armed) words++;
            end else begin
                if (res_word !== '0 && !zero_fault) begin
                    zero_fault = 1'b1;
                    protocol_errors++;
                    $display("res_word is %h while res_valid is low", res_word);
                end
                if (armed && words > 0) close_stream();
            end
            prev_valid = res_valid;
        end
    end

endmodule

// File: tests/mod_exp_sva.sv
// protocol assertions for the exponentiator top level
// bound into every mod_exp_top instance
`include "mod_exp_defines.svh"

module mod_exp_sva (
    input logic clk,
    input logic reset,
    input logic get_result,
    input logic busy,
    input logic result_ready,
    input logic res_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NW = `NUM_WORDS;

    int fail_count = 0;

    busy_not_ready: assert property (@(posedge clk) disable iff (reset)
        !(busy && result_ready))
        else begin
            fail_count++;
            $error("busy and result_ready high together");
        end

    stream_length: assert property (@(posedge clk) disable iff (reset)
        $rose(res_valid) |-> res_valid [*NW] ##1 !res_valid)
        else begin
            fail_count++;
            $error("res_valid did not last exactly %0d cycles", NW);
        end

    // stream only follows a request taken in complete
    stream_request: assert property (@(posedge clk) disable iff (reset)
        $rose(res_valid) |-> $past(get_result && result_ready))
        else begin
            fail_count++;
            $error("res_valid rose without get_result while result_ready");
        end

endmodule

bind mod_exp_top mod_exp_sva mod_exp_sva_i (
    .clk          (clk),
    .reset        (reset),
    .get_result   (get_result),
    .busy         (busy),
    .result_ready (result_ready),
    .res_valid    (res_valid)
);

// File: tests/mod_exp_tb.sv
// testbench top for the modular exponentiator
// case table, operand loading, reference model and watchdog
`include "mod_exp_defines.svh"

module mod_exp_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mod_exp_pkg::*;

    localparam int WW = `WORD_WIDTH;
    localparam int NW = `NUM_WORDS;
    localparam int DW = 2 * `VEC_WIDTH;
    localparam int NUM_TABLE = 7;
    localparam int NUM_CASES = NUM_TABLE + 2;
    localparam int PRODUCT_CYCLES = (4 * NW + 9) * NW;
    localparam int CASE_CYCLES = (2 * `EXP_BITS + 3) * PRODUCT_CYCLES * 2;
    localparam int WATCHDOG_CYCLES = NUM_CASES * CASE_CYCLES;

    typedef struct {
        string name;
        vec_t  m;
        vec_t  e;
        vec_t  n;
    } case_t;

    logic  clk = 1'b0;
    logic  reset;
    logic  start_input;
    logic  start_compute;
    logic  get_result;
    word_t m_word;
    word_t e_word;
    word_t n_word;
    word_t r_word;
    word_t t_word;
    word_t nprime0;
    logic  busy;
    logic  result_ready;
    logic  res_valid;
    word_t res_word;
    int    streams_seen;
    int    check_failures;
    int    seed = 32'h52f2;
    case_t cases [NUM_CASES];

    always #5 clk = ~clk;   // 10 ns period

    mod_exp_top mod_exp_top_i (
        .clk           (clk),
        .reset         (reset),
        .start_input   (start_input),
        .start_compute (start_compute),
        .get_result    (get_result),
        .m_word        (m_word),
        .e_word        (e_word),
        .n_word        (n_word),
        .r_word        (r_word),
        .t_word        (t_word),
        .nprime0       (nprime0),
        .busy          (busy),
        .result_ready  (result_ready),
        .res_valid     (res_valid),
        .res_word      (res_word)
    );

    mod_exp_checker mod_exp_checker_i (
        .clk          (clk),
        .reset        (reset),
        .busy         (busy),
        .result_ready (result_ready),
        .res_valid    (res_valid),
        .res_word     (res_word),
        .streams_seen (streams_seen),
        .fail_count   (check_failures)
    );

    // -n0^-1 mod 2^WW by Newton iteration
    function automatic word_t neg_inverse(word_t n0);
        word_t x;
        x = word_t'(1);
        for (int s = 0; s < $clog2(WW); s++) begin
            x = x * (word_t'(2) - n0 * x);
        end
        return -x;
    endfunction

    // left to right square and multiply
    function automatic vec_t mod_pow(vec_t m, vec_t e, vec_t n);
        logic [DW-1:0] acc;
        logic [DW-1:0] base;
        acc = DW'(1) % n;
        base = DW'(m);
        for (int b = `EXP_BITS - 1; b >= 0; b--) begin
            acc = (acc * acc) % n;
            if (e[b]) acc = (acc * base) % n;
        end
        return vec_t'(acc);
    endfunction

    task automatic fill_table();
        cases[0] = '{"e_one", 64'h0123_4567_89ab_cdef, 64'd1, 64'hf123_4567_89ab_cdf1};
        cases[1] = '{"e_two", 64'h7fff_ffff_ffff_fff0, 64'd2, 64'hffff_ffff_ffff_ffc5};
        cases[2] = '{"e_all_ones", 64'h1234_5678_9abc_def0, 64'hffff_ffff_ffff_ffff,
                     64'hd3a5_c3b1_0f0e_9a6b};
        cases[3] = '{"lead_low_word", 64'h0000_0000_dead_beef, 64'h0000_0000_0000_8a35,
                     64'h8000_0000_0000_0001};
        cases[4] = '{"m_zero", 64'd0, 64'h0000_0000_0001_0003, 64'h0000_0000_0001_0001};
        cases[5] = '{"small_n", 64'd3, 64'h0000_0000_0123_4567, 64'd1000003};
        cases[6] = '{"e_sparse", 64'h0fed_cba9_8765_4321, 64'h8000_0000_0000_0001,
                     64'hffff_ffff_ffff_fffb};
        for (int c = NUM_TABLE; c < NUM_CASES; c++) begin
            cases[c].name = $sformatf("random_%0d", c - NUM_TABLE);
            cases[c].n = {$random(seed), $random(seed)} | 64'h8000_0000_0000_0001;
            cases[c].m = {$random(seed), $random(seed)} % cases[c].n;
            cases[c].e = {$random(seed), $random(seed)};
        end
    endtask

    task automatic load_operands(case_t tc, vec_t r, vec_t t, word_t np);
        @(posedge clk);
        start_input <= 1'b1;
        nprime0 <= np;   // sampled with the start pulse
        for (int w = 0; w < NW; w++) begin
            @(posedge clk);
            start_input <= 1'b0;
            m_word <= tc.m[w * WW +: WW];
            e_word <= tc.e[w * WW +: WW];
            n_word <= tc.n[w * WW +: WW];
            r_word <= r[w * WW +: WW];
            t_word <= t[w * WW +: WW];
        end
    endtask

    task automatic run_case(case_t tc);
        logic [DW-1:0] wide;
        vec_t          r;
        vec_t          t;
        vec_t          expected;
        int            seen;
        int            cycles;
        wide = DW'(1) << `VEC_WIDTH;
        wide = wide % tc.n;
        r = vec_t'(wide);   // R mod n
        wide = (wide * wide) % tc.n;
        t = vec_t'(wide);   // R^2 mod n
        expected = mod_pow(tc.m, tc.e, tc.n);
        load_operands(tc, r, t, neg_inverse(tc.n[WW-1:0]));
        repeat (2) @(posedge clk);   // load_done then wait_compute
        start_compute <= 1'b1;
        @(posedge clk);
        start_compute <= 1'b0;
        get_result <= 1'b1;   // too early and ignored
        @(posedge clk);
        get_result <= 1'b0;
        @(negedge clk);
        if (!busy) begin
            mod_exp_checker_i.note_failure(tc.name, "busy did not rise after start_compute");
            return;
        end
        cycles = 0;
        while (!result_ready && cycles < CASE_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!result_ready) begin
            mod_exp_checker_i.note_failure(tc.name, "result_ready never rose");
            return;
        end
        @(posedge clk);
        mod_exp_checker_i.expect_stream(tc.name, expected);
        seen = streams_seen;
        get_result <= 1'b1;
        @(posedge clk);
        get_result <= 1'b0;
        cycles = 0;
        while (streams_seen == seen && cycles < 2 * NW + 4) begin
            @(posedge clk);
            cycles++;
        end
        if (streams_seen == seen) begin
            mod_exp_checker_i.note_failure(tc.name, "no result stream after get_result");
        end
    endtask

    initial begin
        reset = 1'b1;
        start_input = 1'b0;
        start_compute = 1'b0;
        get_result = 1'b0;
        m_word = '0;
        e_word = '0;
        n_word = '0;
        r_word = '0;
        t_word = '0;
        nprime0 = '0;
        fill_table();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        mod_exp_checker_i.check_quiet("reset_state");

        // strobes in idle, nothing loaded yet
        @(posedge clk);
        start_compute <= 1'b1;
        get_result <= 1'b1;
        @(posedge clk);
        start_compute <= 1'b0;
        get_result <= 1'b0;
        repeat (2 * NW) @(posedge clk);
        mod_exp_checker_i.check_quiet("early_strobes");

        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(cases[c]);
        end
        repeat (4) @(posedge clk);
        mod_exp_checker_i.report_totals();
        if (check_failures == 0 && mod_exp_top_i.mod_exp_sva_i.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d clock cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule
